// ==== zap_dcmp_pkg.sv ====
/*
 * Shared definitions for the pipelined ARM disassembler
 *   Character, slot and instruction widths
 *   Opcode, condition and slot kind enums
 *   Line width helper for a given token width
 */

package zap_dcmp_pkg;

        // ------------------------------
        // Widths
        // ------------------------------

        localparam int INSTR_W    = 32;
        localparam int CHAR_W     = 8;
        localparam int MNEM_CHARS = 4;
        localparam int COND_CHARS = 2;
        localparam int NUM_SLOTS  = 4;          // MLA needs four operands
        localparam int SLOT_VAL_W = 24;         // Wide enough for a branch offset

        // ------------------------------
        // Enums
        // ------------------------------

        // DP opcodes keep the instruction's own 4-bit encoding
        typedef enum logic [4:0] {
                OP_AND = 5'd0,
                OP_EOR = 5'd1,
                OP_SUB = 5'd2,
                OP_RSB = 5'd3,
                OP_ADD = 5'd4,
                OP_ADC = 5'd5,
                OP_SBC = 5'd6,
                OP_RSC = 5'd7,
                OP_TST = 5'd8,
                OP_TEQ = 5'd9,
                OP_CMP = 5'd10,
                OP_CMN = 5'd11,
                OP_ORR = 5'd12,
                OP_MOV = 5'd13,
                OP_BIC = 5'd14,
                OP_MVN = 5'd15,
                OP_MUL = 5'd16,
                OP_MLA = 5'd17,
                OP_B   = 5'd18,
                OP_BL  = 5'd19,
                OP_SWI = 5'd20,
                OP_UNK = 5'd21         // Printed as ????
        } opcode_e;

        // Same encoding as instruction bits 31:28
        typedef enum logic [3:0] {
                COND_EQ, COND_NE, COND_CS, COND_CC,
                COND_MI, COND_PL, COND_VS, COND_VC,
                COND_HI, COND_LS, COND_GE, COND_LT,
                COND_GT, COND_LE, COND_AL, COND_NV
        } cond_e;

        typedef enum logic [1:0] {
                SLOT_NONE,
                SLOT_REG,               // Register number in bits 3:0
                SLOT_IMM8,              // Two hex digits
                SLOT_IMM24              // Six hex digits
        } slot_kind_e;

        // Characters in one output line
        function automatic int line_chars(input int token_chars);
                return MNEM_CHARS + COND_CHARS + 1 + NUM_SLOTS * token_chars
                        + (NUM_SLOTS - 1);
        endfunction

endpackage : zap_dcmp_pkg

// ==== zap_dcmp_classify.sv ====
/*
 * First pipeline stage of the disassembler
 *   Recognizes branch, SWI, MUL/MLA and the two DP forms
 *   Fills four operand slot requests per instruction
 *   Registers opcode, condition and slots in one cycle
 */

module zap_dcmp_classify (
        input  logic                                    i_clk,
        input  logic                                    i_rst_n,
        input  logic                                    i_dav,
        input  logic [zap_dcmp_pkg::INSTR_W-1:0]        i_instruction,
        output logic                                    o_dav,
        output zap_dcmp_pkg::opcode_e                   o_opcode,
        output zap_dcmp_pkg::cond_e                     o_cond,
        output zap_dcmp_pkg::slot_kind_e                o_slot_kind [zap_dcmp_pkg::NUM_SLOTS],
        output logic [zap_dcmp_pkg::SLOT_VAL_W-1:0]     o_slot_value [zap_dcmp_pkg::NUM_SLOTS]
);

        import zap_dcmp_pkg::*;

        logic [3:0]             dp_op;
        logic                   dp_ok;
        opcode_e                dec_opcode;
        slot_kind_e             dec_kind [NUM_SLOTS];
        logic [SLOT_VAL_W-1:0]  dec_value [NUM_SLOTS];

        assign dp_op = i_instruction[24:21];

        // TST/TEQ/CMP/CMN without S are not data processing
        assign dp_ok = !(dp_op[3:2] == 2'b10 && !i_instruction[20]);

        // ------------------------------
        // Decode
        // ------------------------------

        always_comb
        begin
                dec_opcode = OP_UNK;
                dec_kind   = '{default: SLOT_NONE};
                dec_value  = '{default: '0};

                if (i_instruction[27:25] == 3'b101)                     // B, BL
                begin
                        dec_opcode   = i_instruction[24] ? OP_BL : OP_B;
                        dec_kind[0]  = SLOT_IMM24;
                        dec_value[0] = i_instruction[23:0];
                end
                else if (i_instruction[27:24] == 4'b1111)               // SWI
                begin
                        dec_opcode   = OP_SWI;
                        dec_kind[0]  = SLOT_IMM24;
                        dec_value[0] = i_instruction[23:0];
                end
                else if (i_instruction[27:22] == 6'd0 && i_instruction[7:4] == 4'b1001)
                begin
                        dec_opcode   = i_instruction[21] ? OP_MLA : OP_MUL;
                        dec_kind[0]  = SLOT_REG;
                        dec_value[0] = SLOT_VAL_W'(i_instruction[19:16]);   // Rd
                        dec_kind[1]  = SLOT_REG;
                        dec_value[1] = SLOT_VAL_W'(i_instruction[3:0]);     // Rm
                        dec_kind[2]  = SLOT_REG;
                        dec_value[2] = SLOT_VAL_W'(i_instruction[11:8]);    // Rs
                        if (i_instruction[21])
                        begin
                                dec_kind[3]  = SLOT_REG;                   // Accumulator
                                dec_value[3] = SLOT_VAL_W'(i_instruction[15:12]);
                        end
                end
                else if (i_instruction[27:25] == 3'b001 && dp_ok)       // DP immediate
                begin
                        dec_opcode   = opcode_e'({1'b0, dp_op});
                        dec_kind[0]  = SLOT_REG;
                        dec_value[0] = SLOT_VAL_W'(i_instruction[15:12]);
                        dec_kind[1]  = SLOT_REG;
                        dec_value[1] = SLOT_VAL_W'(i_instruction[19:16]);
                        dec_kind[2]  = SLOT_IMM8;
                        dec_value[2] = SLOT_VAL_W'(i_instruction[7:0]);
                        dec_kind[3]  = SLOT_IMM8;                          // Rotate field
                        dec_value[3] = SLOT_VAL_W'(i_instruction[11:8]);
                end
                else if (i_instruction[27:25] == 3'b000 && i_instruction[11:4] == 8'd0
                         && dp_ok)
                begin
                        // Plain register, no shift
                        dec_opcode   = opcode_e'({1'b0, dp_op});
                        dec_kind[0]  = SLOT_REG;
                        dec_value[0] = SLOT_VAL_W'(i_instruction[15:12]);
                        dec_kind[1]  = SLOT_REG;
                        dec_value[1] = SLOT_VAL_W'(i_instruction[19:16]);
                        dec_kind[2]  = SLOT_REG;
                        dec_value[2] = SLOT_VAL_W'(i_instruction[3:0]);
                end
        end

        // ------------------------------
        // Stage register
        // ------------------------------

        always_ff @(posedge i_clk)
        begin
                if (!i_rst_n)
                        o_dav <= 1'b0;
                else
                        o_dav <= i_dav;
        end

        always_ff @(posedge i_clk)
        begin
                if (i_dav)
                begin
                        o_opcode     <= dec_opcode;
                        o_cond       <= cond_e'(i_instruction[31:28]);
                        o_slot_kind  <= dec_kind;
                        o_slot_value <= dec_value;
                end
        end

endmodule : zap_dcmp_classify

// ==== zap_dcmp_operand.sv ====
/*
 * Operand formatter
 *   Turns one slot request into a left-justified ASCII token
 *   Registers, 8-bit and 24-bit hex immediates
 */

module zap_dcmp_operand #(
        parameter int TOKEN_CHARS = 8
) (
        input  logic                                            i_clk,
        input  logic                                            i_rst_n,
        input  logic                                            i_dav,
        input  zap_dcmp_pkg::slot_kind_e                        i_kind,
        input  logic [zap_dcmp_pkg::SLOT_VAL_W-1:0]             i_value,
        output logic                                            o_dav,
        output logic                                            o_present,
        output logic [TOKEN_CHARS*zap_dcmp_pkg::CHAR_W-1:0]     o_token
);

        import zap_dcmp_pkg::*;

        logic [CHAR_W-1:0]              chars [TOKEN_CHARS];
        logic [TOKEN_CHARS*CHAR_W-1:0]  token;

        // One uppercase hex digit
        function automatic logic [CHAR_W-1:0] hex_char(input logic [3:0] nib);
                if (nib < 4'd10)
                        return CHAR_W'("0") + CHAR_W'(nib);
                return CHAR_W'("A") + CHAR_W'(nib) - CHAR_W'(10);
        endfunction

        always_comb
        begin
                for (int i = 0; i < TOKEN_CHARS; i++)
                        chars[i] = " ";

                case (i_kind)
                SLOT_REG:
                begin
                        case (i_value[3:0])
                        4'd13:  {chars[0], chars[1]} = "SP";
                        4'd14:  {chars[0], chars[1]} = "LR";
                        4'd15:  {chars[0], chars[1]} = "PC";
                        4'd10, 4'd11, 4'd12:
                        begin
                                chars[0] = "R";
                                chars[1] = "1";
                                chars[2] = hex_char(i_value[3:0] - 4'd10);
                        end
                        default:
                        begin
                                chars[0] = "R";
                                chars[1] = hex_char(i_value[3:0]);
                        end
                        endcase
                end
                SLOT_IMM8:
                begin
                        chars[0] = "#";
                        chars[1] = hex_char(i_value[7:4]);
                        chars[2] = hex_char(i_value[3:0]);
                end
                SLOT_IMM24:
                begin
                        chars[0] = "#";
                        for (int d = 0; d < 6; d++)
                                chars[1+d] = hex_char(i_value[SLOT_VAL_W-1-4*d -: 4]);
                end
                default: ;      // Blank token
                endcase

                // First character ends up in the top byte
                for (int i = 0; i < TOKEN_CHARS; i++)
                        token[(TOKEN_CHARS-1-i)*CHAR_W +: CHAR_W] = chars[i];
        end

        always_ff @(posedge i_clk)
        begin
                if (!i_rst_n)
                        o_dav <= 1'b0;
                else
                        o_dav <= i_dav;
        end

        always_ff @(posedge i_clk)
        begin
                if (i_dav)
                begin
                        o_token   <= token;
                        o_present <= (i_kind != SLOT_NONE);
                end
        end

endmodule : zap_dcmp_operand

// ==== zap_dcmp_line.sv ====
/*
 * Line assembler, last pipeline stage
 *   Mnemonic and condition text tables
 *   Joins the four tokens with comma or space separators
 */

module zap_dcmp_line #(
        parameter int TOKEN_CHARS = 8
) (
        input  logic                                            i_clk,
        input  logic                                            i_rst_n,
        input  logic                                            i_dav,
        input  zap_dcmp_pkg::opcode_e                           i_opcode,
        input  zap_dcmp_pkg::cond_e                             i_cond,
        input  logic [TOKEN_CHARS*zap_dcmp_pkg::CHAR_W-1:0]     i_token
                                                                [zap_dcmp_pkg::NUM_SLOTS],
        input  logic [zap_dcmp_pkg::NUM_SLOTS-1:0]              i_present,
        output logic                                            o_dav,
        output logic
                [zap_dcmp_pkg::line_chars(TOKEN_CHARS)*zap_dcmp_pkg::CHAR_W-1:0] o_text
);

        import zap_dcmp_pkg::*;

        localparam int                            LINE_W = line_chars(TOKEN_CHARS) * CHAR_W;
        localparam logic [TOKEN_CHARS*CHAR_W-1:0] BLANK  = {TOKEN_CHARS{" "}};

        logic [TOKEN_CHARS*CHAR_W-1:0]  tok [NUM_SLOTS];
        logic [LINE_W-1:0]              line;

        function automatic logic [MNEM_CHARS*CHAR_W-1:0] mnem_text(input opcode_e op);
                case (op)
                OP_AND: return "AND ";
                OP_EOR: return "EOR ";
                OP_SUB: return "SUB ";
                OP_RSB: return "RSB ";
                OP_ADD: return "ADD ";
                OP_ADC: return "ADC ";
                OP_SBC: return "SBC ";
                OP_RSC: return "RSC ";
                OP_TST: return "TST ";
                OP_TEQ: return "TEQ ";
                OP_CMP: return "CMP ";
                OP_CMN: return "CMN ";
                OP_ORR: return "ORR ";
                OP_MOV: return "MOV ";
                OP_BIC: return "BIC ";
                OP_MVN: return "MVN ";
                OP_MUL: return "MUL ";
                OP_MLA: return "MLA ";
                OP_B:   return "B   ";
                OP_BL:  return "BL  ";
                OP_SWI: return "SWI ";
                default: return "????";
                endcase
        endfunction

        // Table indexed by the condition encoding
        function automatic logic [COND_CHARS*CHAR_W-1:0] cond_text(input cond_e cc);
                logic [16*COND_CHARS*CHAR_W-1:0] names;

                names = "EQNECSCCMIPLVSVCHILSGELTGTLEALNV";
                return names[(15 - int'(cc))*COND_CHARS*CHAR_W +: COND_CHARS*CHAR_W];
        endfunction

        // ------------------------------
        // Line build
        // ------------------------------

        always_comb
        begin
                for (int s = 0; s < NUM_SLOTS; s++)
                        tok[s] = i_present[s] ? i_token[s] : BLANK;

                line = LINE_W'({mnem_text(i_opcode), cond_text(i_cond), " ", tok[0]});

                // Shift in separator and token one slot at a time
                for (int s = 1; s < NUM_SLOTS; s++)
                        line = (line << ((TOKEN_CHARS + 1) * CHAR_W))
                                | LINE_W'({(i_present[s] ? "," : " "), tok[s]});
        end

        always_ff @(posedge i_clk)
        begin
                if (!i_rst_n)
                        o_dav <= 1'b0;
                else
                        o_dav <= i_dav;
        end

        always_ff @(posedge i_clk)
        begin
                if (i_dav)
                        o_text <= line;
        end

endmodule : zap_dcmp_line

// ==== zap_dcmp_top.sv ====
/*
 * Disassembler top level, three clocks from strobe to line
 *   Classifier, one formatter per slot, line assembler
 *   Opcode and condition delay beside formatter 0
 */

module zap_dcmp_top #(
        parameter int TOKEN_CHARS = 8          // At least 7 for a 24-bit immediate
) (
        input  logic                                    i_clk,
        input  logic                                    i_rst_n,
        input  logic                                    i_dav,
        input  logic [zap_dcmp_pkg::INSTR_W-1:0]        i_instruction,
        output logic                                    o_dav,
        output logic
                [zap_dcmp_pkg::line_chars(TOKEN_CHARS)*zap_dcmp_pkg::CHAR_W-1:0] o_text
);

        import zap_dcmp_pkg::*;

        logic                           cls_dav;
        opcode_e                        cls_opcode;
        cond_e                          cls_cond;
        slot_kind_e                     cls_kind [NUM_SLOTS];
        logic [SLOT_VAL_W-1:0]          cls_value [NUM_SLOTS];

        logic [NUM_SLOTS-1:0]           fmt_dav;
        logic [NUM_SLOTS-1:0]           fmt_present;
        logic [TOKEN_CHARS*CHAR_W-1:0]  fmt_token [NUM_SLOTS];
        opcode_e                        hdr_opcode;
        cond_e                          hdr_cond;

        zap_dcmp_classify u_classify (
                .i_clk          (i_clk),
                .i_rst_n        (i_rst_n),
                .i_dav          (i_dav),
                .i_instruction  (i_instruction),
                .o_dav          (cls_dav),
                .o_opcode       (cls_opcode),
                .o_cond         (cls_cond),
                .o_slot_kind    (cls_kind),
                .o_slot_value   (cls_value)
        );

        for (genvar s = 0; s < NUM_SLOTS; s++)
        begin : g_slot
                zap_dcmp_operand #(.TOKEN_CHARS(TOKEN_CHARS)) u_operand (
                        .i_clk          (i_clk),
                        .i_rst_n        (i_rst_n),
                        .i_dav          (cls_dav),
                        .i_kind         (cls_kind[s]),
                        .i_value        (cls_value[s]),
                        .o_dav          (fmt_dav[s]),
                        .o_present      (fmt_present[s]),
                        .o_token        (fmt_token[s])
                );

                if (s == 0)
                begin : g_hdr
                        // Keeps opcode and condition level with the tokens
                        always_ff @(posedge i_clk)
                        begin
                                if (cls_dav)
                                begin
                                        hdr_opcode <= cls_opcode;
                                        hdr_cond   <= cls_cond;
                                end
                        end
                end
        end

        zap_dcmp_line #(.TOKEN_CHARS(TOKEN_CHARS)) u_line (
                .i_clk          (i_clk),
                .i_rst_n        (i_rst_n),
                .i_dav          (&fmt_dav),     // All slots move in lockstep
                .i_opcode       (hdr_opcode),
                .i_cond         (hdr_cond),
                .i_token        (fmt_token),
                .i_present      (fmt_present),
                .o_dav          (o_dav),
                .o_text         (o_text)
        );

endmodule : zap_dcmp_top

// ==== tb_zap_dcmp.sv ====
/*
 * Testbench for the pipelined ARM disassembler
 *   Clock, reset and idle checks, latency of one strobe
 *   Table of instructions and expected lines, run back to back
 *   and again with random gaps, single compare task
 */

module tb_zap_dcmp;

        import zap_dcmp_pkg::*;

        localparam int TOKEN_CHARS = 8;
        localparam int LINE_CHARS  = MNEM_CHARS + COND_CHARS + 1 + NUM_SLOTS * TOKEN_CHARS
                                     + (NUM_SLOTS - 1);
        localparam int LINE_W      = LINE_CHARS * CHAR_W;
        localparam int TIMEOUT     = 50;        // Clocks allowed per wait

        logic                   i_clk;
        logic                   i_rst_n;
        logic                   i_dav;
        logic [INSTR_W-1:0]     i_instruction;
        logic                   o_dav;
        logic [LINE_W-1:0]      o_text;

        logic [INSTR_W-1:0]     tbl_instr [$];
        logic [LINE_W-1:0]      tbl_line [$];
        logic [LINE_W-1:0]      exp_q [$];     // Lines still in flight

        zap_dcmp_top #(.TOKEN_CHARS(TOKEN_CHARS)) u_zap_dcmp_top (
                .i_clk          (i_clk),
                .i_rst_n        (i_rst_n),
                .i_dav          (i_dav),
                .i_instruction  (i_instruction),
                .o_dav          (o_dav),
                .o_text         (o_text)
        );

        always #4 i_clk = ~i_clk;

        // ------------------------------
        // Helpers
        // ------------------------------

        task automatic stop_with_failure(input string why);
                $display("%s", why);
                $display("Simulation FAILED");
                $fatal(1);
        endtask

        task automatic check_value(input string name, input logic [LINE_W-1:0] got,
                                   input logic [LINE_W-1:0] exp);
                if (got !== exp)
                begin
                        $display("error: %s got %h expected %h", name, got, exp);
                        stop_with_failure("mismatch on a DUT output");
                end
        endtask

        // Left-justify and fill with spaces
        function automatic string pad_text(input string t, input int n);
                string r;

                r = t;
                while (r.len() < n)
                        r = {r, " "};
                return r;
        endfunction

        // Layout: mnemonic, condition, space, tokens with separators
        function automatic logic [LINE_W-1:0] make_line(input string mnem, input string cc,
                        input string t0, input string t1, input string t2, input string t3);
                string             toks [NUM_SLOTS];
                string             txt;
                logic [LINE_W-1:0] v;

                toks[0] = t0;
                toks[1] = t1;
                toks[2] = t2;
                toks[3] = t3;
                txt = {pad_text(mnem, MNEM_CHARS), cc, " ", pad_text(toks[0], TOKEN_CHARS)};
                for (int s = 1; s < NUM_SLOTS; s++)
                begin
                        if (toks[s] == "")
                                txt = {txt, " "};       // Blank slot follows
                        else
                                txt = {txt, ","};
                        txt = {txt, pad_text(toks[s], TOKEN_CHARS)};
                end
                v = '0;
                for (int i = 0; i < LINE_CHARS; i++)
                        v[(LINE_CHARS-1-i)*CHAR_W +: CHAR_W] = txt[i];
                return v;
        endfunction

        task automatic add_entry(input logic [INSTR_W-1:0] instr, input string mnem,
                        input string cc, input string t0, input string t1,
                        input string t2, input string t3);
                tbl_instr.push_back(instr);
                tbl_line.push_back(make_line(mnem, cc, t0, t1, t2, t3));
        endtask

        task automatic idle_cycle();
                @(posedge i_clk);
                #1;
                i_dav         = 1'b0;
                i_instruction = $urandom;       // Junk while not valid
        endtask

        // ------------------------------
        // Stimulus and response
        // ------------------------------

        task automatic drive_table(input bit random_gaps);
                int gap;

                for (int i = 0; i < tbl_instr.size(); i++)
                begin
                        gap = random_gaps ? int'($urandom % 4) : 0;
                        repeat (gap)
                                idle_cycle();
                        @(posedge i_clk);
                        #1;
                        i_dav         = 1'b1;
                        i_instruction = tbl_instr[i];
                        exp_q.push_back(tbl_line[i]);
                end
                idle_cycle();
        endtask

        task automatic collect_lines(input int count);
                int waited;

                for (int n = 0; n < count; n++)
                begin
                        waited = 0;
                        do
                        begin
                                @(negedge i_clk);
                                waited++;
                        end while (!o_dav && waited < TIMEOUT);
                        if (!o_dav)
                                stop_with_failure("timed out waiting for an output line");
                        else if (exp_q.size() == 0)
                                stop_with_failure("output line appeared with no input strobe");
                        else
                                check_value("o_text", o_text, exp_q.pop_front());
                end
        endtask

        // One strobe, then count clocks until the line shows up
        task automatic measure_latency();
                int cycles;

                @(posedge i_clk);
                #1;
                i_dav         = 1'b1;
                i_instruction = tbl_instr[0];
                idle_cycle();
                cycles = 0;
                do
                begin
                        @(negedge i_clk);
                        cycles++;
                end while (!o_dav && cycles < TIMEOUT);
                if (!o_dav)
                        stop_with_failure("timed out waiting for the first output line");
                else
                begin
                        check_value("latency", LINE_W'(cycles), LINE_W'(3));
                        check_value("o_text", o_text, tbl_line[0]);
                end
        endtask

        task automatic expect_quiet(input int cycles);
                repeat (cycles)
                begin
                        @(negedge i_clk);
                        check_value("o_dav", LINE_W'(o_dav), '0);
                end
        endtask

        initial
        begin
                void'($urandom(9));
                i_clk         = 1'b0;
                i_rst_n       = 1'b0;
                i_dav         = 1'b0;
                i_instruction = '0;

                add_entry(32'h02821A3C, "ADD", "EQ", "R1", "R2", "#3C", "#0A");
                add_entry(32'hE1A00003, "MOV", "AL", "R0", "R0", "R3", "");
                add_entry(32'h135400FF, "CMP", "NE", "R0", "R4", "#FF", "#00");
                add_entry(32'h1155000C, "CMP", "NE", "R0", "R5", "R12", "");
                add_entry(32'hE08FE00D, "ADD", "AL", "LR", "PC", "SP", "");
                add_entry(32'hE0020493, "MUL", "AL", "R2", "R3", "R4", "");
                add_entry(32'h10258796, "MLA", "NE", "R5", "R6", "R7", "R8");
                add_entry(32'hEA123456, "B", "AL", "#123456", "", "", "");
                add_entry(32'hCBFFFFFE, "BL", "GT", "#FFFFFE", "", "", "");
                add_entry(32'hEF00ABCD, "SWI", "AL", "#00ABCD", "", "", "");
                add_entry(32'hE5910000, "????", "AL", "", "", "", "");     // LDR
                add_entry(32'hE8BD8000, "????", "AL", "", "", "", "");     // LDM
                add_entry(32'hE10F0000, "????", "AL", "", "", "", "");     // MRS
                add_entry(32'hB0810102, "????", "LT", "", "", "", "");     // LSL #2

                // Reset held for three edges
                repeat (3)
                begin
                        @(posedge i_clk);
                        #1;
                        check_value("o_dav", LINE_W'(o_dav), '0);
                end
                i_rst_n = 1'b1;
                expect_quiet(4);

                measure_latency();
                expect_quiet(3);

                fork
                        drive_table(1'b0);
                        collect_lines(tbl_instr.size());
                join
                expect_quiet(6);

                fork
                        drive_table(1'b1);
                        collect_lines(tbl_instr.size());
                join
                expect_quiet(8);        // Nothing duplicated

                $display("Simulation PASSED");
                $finish;
        end

endmodule : tb_zap_dcmp

// ==== files.f ====
zap_dcmp_pkg.sv
zap_dcmp_classify.sv
zap_dcmp_operand.sv
zap_dcmp_line.sv
zap_dcmp_top.sv
tb_zap_dcmp.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the disassembler testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_zap_dcmp -f files.f \
        --Mdir obj_dir -o sim_zap_dcmp

# The simulation result is judged from the log
./obj_dir/sim_zap_dcmp > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation PASSED" sim.log; then
        exit 0
else
        exit 1
fi
